// ==== common/cmd_cfg.svh ====
`ifndef CMD_CFG_SVH
`define CMD_CFG_SVH

// Widths
`define CMD_ID_BITS 5
`define ARG_BITS 32
`define MAX_ARGS 8
`define ARG_IDX_BITS 3
`define MAX_PARAMS 8
`define PARAM_IDX_BITS 3
`define LEN_BITS 8

// Functional units
`define NUNITS 2
`define UNIT_BITS 1
`define UNIT_SYSTEM 0
`define UNIT_GPIO 1
`define NGPIO 8

`define FW_VERSION 32'h0001_0203

// Host command IDs
`define CMD_GET_VERSION 0
`define CMD_GET_TIME 2
`define CMD_SET_DIGITAL_OUT 15
`define CMD_SHUTDOWN 19

// Response IDs
`define RSP_GET_VERSION 0
`define RSP_GET_TIME 1

`endif

// ==== common/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

// One parameter word returned by a unit.
// The encoder picks the view from the separate raw flag.
typedef union packed {
	logic signed [31:0] as_value; // Sent as minimal signed VLQ.
	struct packed {
		logic [23:0] pad;
		logic [7:0] data; // Sent as a single byte.
	} as_raw;
} param_word_u;

endpackage

`default_nettype wire

// ==== command/cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module cmd_parser (
	input wire clk,
	input wire reset,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output logic msg_rd_en,
	input wire dispatch_idle,
	output logic arg_write,
	output logic [`ARG_IDX_BITS-1:0] arg_idx,
	output logic [`ARG_BITS-1:0] arg_data,
	output logic cmd_valid,
	output logic [`CMD_ID_BITS-1:0] cmd_id,
	output logic [`UNIT_BITS-1:0] cmd_unit,
	output logic cmd_has_response
);

localparam [2:0] S_ID = 3'd0;
localparam [2:0] S_ARG = 3'd1;
localparam [2:0] S_DISPATCH = 3'd2;
localparam [2:0] S_WAIT_BUSY = 3'd3;
localparam [2:0] S_WAIT_IDLE = 3'd4;
localparam [2:0] S_HOLD = 3'd5;

localparam logic [`UNIT_BITS-1:0] UNIT_SYS = `UNIT_SYSTEM;
localparam logic [`UNIT_BITS-1:0] UNIT_IO = `UNIT_GPIO;
localparam logic [`ARG_IDX_BITS:0] NARGS_DOUT = 2;

logic [2:0] state;
logic [`ARG_IDX_BITS:0] arg_count;
logic first_byte;
logic take;
logic [`ARG_BITS-1:0] arg_next;

logic tab_valid;
logic [`UNIT_BITS-1:0] tab_unit;
logic [`ARG_IDX_BITS:0] tab_nargs;
logic tab_rsp;

// Command table.
always_comb begin
	tab_valid = 1'b1;
	tab_unit = UNIT_SYS;
	tab_nargs = '0;
	tab_rsp = 1'b0;
	case (msg_data)
		`CMD_GET_VERSION: tab_rsp = 1'b1;
		`CMD_GET_TIME: tab_rsp = 1'b1;
		`CMD_SHUTDOWN: tab_rsp = 1'b0;
		`CMD_SET_DIGITAL_OUT: begin
			tab_unit = UNIT_IO;
			tab_nargs = NARGS_DOUT;
		end
		default: tab_valid = 1'b0;
	endcase
end

// One pop, then a gap cycle while the queue advances.
assign take = msg_ready && !msg_rd_en && dispatch_idle && (state == S_ID || state == S_ARG);

always_comb begin
	if (first_byte)
		arg_next = {{(`ARG_BITS-7){msg_data[6] & msg_data[5]}}, msg_data[6:0]};
	else
		arg_next = {arg_data[`ARG_BITS-8:0], msg_data[6:0]};
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= S_ID;
		msg_rd_en <= 1'b0;
		arg_write <= 1'b0;
		cmd_valid <= 1'b0;
		first_byte <= 1'b1;
		arg_idx <= '0;
	end else begin
		msg_rd_en <= take;
		arg_write <= 1'b0;
		cmd_valid <= 1'b0;
		if (arg_write)
			arg_idx <= arg_idx + 1'b1;
		case (state)
			S_ID: if (take && tab_valid) begin
				cmd_id <= msg_data[`CMD_ID_BITS-1:0];
				cmd_unit <= tab_unit;
				cmd_has_response <= tab_rsp;
				arg_count <= tab_nargs;
				arg_idx <= '0;
				first_byte <= 1'b1;
				state <= (tab_nargs == '0) ? S_DISPATCH : S_ARG;
			end
			S_ARG: if (take) begin
				arg_data <= arg_next;
				first_byte <= !msg_data[7];
				if (!msg_data[7]) begin
					arg_write <= 1'b1;
					if ({1'b0, arg_idx} + 1'b1 == arg_count)
						state <= S_DISPATCH;
				end
			end
			S_DISPATCH: begin
				cmd_valid <= 1'b1;
				state <= S_WAIT_BUSY;
			end
			S_WAIT_BUSY: state <= S_WAIT_IDLE; // Dispatcher leaves idle here.
			S_WAIT_IDLE: if (dispatch_idle)
				state <= S_HOLD;
			default: state <= S_ID;
		endcase
	end
end

a_arg_idx: assert property (@(posedge clk) disable iff (reset)
	arg_write |-> ({1'b0, arg_idx} < arg_count) && (arg_count <= `MAX_ARGS));

endmodule

`default_nettype wire

// ==== command/cmd_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module cmd_dispatch (
	input wire clk,
	input wire reset,
	input wire arg_write,
	input wire [`ARG_IDX_BITS-1:0] arg_idx,
	input wire [`ARG_BITS-1:0] arg_data,
	input wire cmd_valid,
	input wire [`CMD_ID_BITS-1:0] cmd_id,
	input wire [`UNIT_BITS-1:0] cmd_unit,
	input wire cmd_has_response,
	output logic dispatch_idle,
	output logic [`CMD_ID_BITS-1:0] unit_cmd_id,
	output logic [`ARG_BITS-1:0] unit_arg_data,
	output logic [`NUNITS-1:0] unit_cmd_ready,
	input wire [`NUNITS-1:0] unit_arg_advance,
	input wire [`NUNITS-1:0] unit_param_write,
	input wire cmd_pkg::param_word_u unit_param_data [`NUNITS],
	input wire [`NUNITS-1:0] unit_param_raw,
	input wire [`NUNITS-1:0] unit_cmd_done,
	output logic param_write,
	output cmd_pkg::param_word_u param_data,
	output logic param_raw,
	output logic rsp_start,
	output logic [7:0] rsp_id,
	input wire rsp_busy
);

localparam [1:0] D_IDLE = 2'd0;
localparam [1:0] D_READY = 2'd1;
localparam [1:0] D_WAIT_DONE = 2'd2;
localparam [1:0] D_WAIT_ENC = 2'd3;

logic [1:0] state;
logic [`ARG_BITS-1:0] args [`MAX_ARGS];
logic [`ARG_IDX_BITS-1:0] arg_ptr;
logic [`UNIT_BITS-1:0] unit_sel;
logic has_rsp;
logic sel_advance;
logic sel_done;

assign dispatch_idle = state == D_IDLE;
assign sel_advance = unit_arg_advance[unit_sel] && state == D_WAIT_DONE;
assign sel_done = unit_cmd_done[unit_sel] && state == D_WAIT_DONE;

// Only a command that answers fills the encoder buffer.
assign param_write = unit_param_write[unit_sel] && state == D_WAIT_DONE && has_rsp;
assign param_data = unit_param_data[unit_sel];
assign param_raw = unit_param_raw[unit_sel];

always_ff @(posedge clk) begin
	if (arg_write)
		args[arg_idx] <= arg_data;
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= D_IDLE;
		unit_cmd_ready <= '0;
		rsp_start <= 1'b0;
	end else begin
		unit_cmd_ready <= '0;
		rsp_start <= 1'b0;
		case (state)
			D_IDLE: if (cmd_valid) begin
				unit_cmd_id <= cmd_id;
				unit_sel <= cmd_unit;
				has_rsp <= cmd_has_response;
				state <= D_READY;
			end
			D_READY: begin
				unit_arg_data <= args[0]; // First argument rides with cmd_ready.
				arg_ptr <= `ARG_IDX_BITS'(1);
				unit_cmd_ready[unit_sel] <= 1'b1;
				state <= D_WAIT_DONE;
			end
			D_WAIT_DONE: begin
				if (sel_advance) begin
					unit_arg_data <= args[arg_ptr];
					arg_ptr <= arg_ptr + 1'b1;
				end
				if (sel_done) begin
					if (has_rsp) begin
						rsp_start <= 1'b1;
						rsp_id <= param_data.as_raw.data;
						state <= D_WAIT_ENC;
					end else begin
						state <= D_IDLE;
					end
				end
			end
			default: if (!rsp_busy)
				state <= D_IDLE;
		endcase
	end
end

a_done_sel: assert property (@(posedge clk) disable iff (reset)
	|unit_cmd_done |-> state == D_WAIT_DONE &&
		unit_cmd_done == (`NUNITS'(1) << unit_sel));

endmodule

`default_nettype wire

// ==== command/rsp_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module rsp_encoder (
	input wire clk,
	input wire reset,
	input wire param_write,
	input wire cmd_pkg::param_word_u param_data,
	input wire param_raw,
	input wire rsp_start,
	input wire [7:0] rsp_id,
	output logic rsp_busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input wire send_ring_full,
	output logic [`LEN_BITS-1:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input wire send_fifo_full
);

localparam [1:0] E_IDLE = 2'd0;
localparam [1:0] E_ID = 2'd1;
localparam [1:0] E_DATA = 2'd2;
localparam [1:0] E_LEN = 2'd3;

logic [1:0] state;
cmd_pkg::param_word_u params [`MAX_PARAMS];
logic [`MAX_PARAMS-1:0] raw_flags;
logic [`PARAM_IDX_BITS:0] nparams;
logic [`PARAM_IDX_BITS-1:0] cur;
logic [7:0] id_byte;
logic [`LEN_BITS-1:0] len;
logic first;
logic [2:0] grp;
cmd_pkg::param_word_u word;
logic [34:0] ext;
logic [2:0] grp_now;
logic param_last;

// Minimal signed VLQ length in bytes.
function automatic logic [2:0] vlq_len(input logic signed [31:0] v);
	if (v >= -32 && v < 96)
		return 3'd1;
	else if (v >= -4096 && v < 12288)
		return 3'd2;
	else if (v >= -(1 << 19) && v < 3 * (1 << 19))
		return 3'd3;
	else if (v >= -(1 << 26) && v < 3 * (1 << 26))
		return 3'd4;
	return 3'd5;
endfunction

assign word = params[cur];
assign ext = {{3{word.as_value[31]}}, word.as_value}; // 5 groups of 7.
assign grp_now = first ? vlq_len(word.as_value) - 3'd1 : grp;
assign param_last = raw_flags[cur] || grp_now == 3'd0;

always_comb begin
	if (state == E_ID)
		send_ring_data = id_byte;
	else if (raw_flags[cur])
		send_ring_data = word.as_raw.data;
	else
		send_ring_data = {grp_now != 3'd0, ext[7 * grp_now +: 7]};
end

assign send_ring_wr_en = (state == E_ID || state == E_DATA) && !send_ring_full;
assign send_fifo_wr_en = state == E_LEN && !send_fifo_full;
assign send_fifo_data = len;
assign rsp_busy = state != E_IDLE || rsp_start; // Covers the start cycle.

always_ff @(posedge clk) begin
	if (param_write) begin
		params[nparams[`PARAM_IDX_BITS-1:0]] <= param_data;
		raw_flags[nparams[`PARAM_IDX_BITS-1:0]] <= param_raw;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= E_IDLE;
		nparams <= '0;
	end else begin
		if (param_write)
			nparams <= nparams + 1'b1;
		case (state)
			E_IDLE: if (rsp_start) begin
				id_byte <= rsp_id;
				cur <= '0;
				first <= 1'b1;
				state <= E_ID;
			end
			E_ID: if (send_ring_wr_en) begin
				len <= `LEN_BITS'(1);
				state <= (nparams == '0) ? E_LEN : E_DATA;
			end
			E_DATA: if (send_ring_wr_en) begin
				len <= len + 1'b1;
				if (param_last) begin
					first <= 1'b1;
					if ({1'b0, cur} + 1'b1 == nparams)
						state <= E_LEN;
					else
						cur <= cur + 1'b1;
				end else begin
					first <= 1'b0;
					grp <= grp_now - 3'd1;
				end
			end
			default: if (send_fifo_wr_en) begin
				nparams <= '0; // Buffer is free for the next command.
				state <= E_IDLE;
			end
		endcase
	end
end

// A byte held back by a full ring is the one offered next.
a_ring_full: assert property (@(posedge clk) disable iff (reset)
	send_ring_full && (state == E_ID || state == E_DATA) |->
		!send_ring_wr_en ##1 $stable(send_ring_data));

a_start_idle: assert property (@(posedge clk) disable iff (reset)
	rsp_start |-> state == E_IDLE);

endmodule

`default_nettype wire

// ==== rtl/system_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module system_unit (
	input wire clk,
	input wire reset,
	input wire [63:0] systime,
	input wire [`CMD_ID_BITS-1:0] cmd_id,
	input wire [`ARG_BITS-1:0] arg_data,
	input wire cmd_ready,
	output logic arg_advance,
	output logic param_write,
	output cmd_pkg::param_word_u param_data,
	output logic param_raw,
	output logic cmd_done,
	output logic shutdown
);

localparam [2:0] ST_IDLE = 3'd0;
localparam [2:0] ST_VER = 3'd1;
localparam [2:0] ST_TLO = 3'd2;
localparam [2:0] ST_THI = 3'd3;
localparam [2:0] ST_DONE = 3'd4;

logic [2:0] state;
logic [63:0] time_latched;
logic [7:0] rsp_id;

assign arg_advance = 1'b0; // System commands take no arguments.
assign param_raw = 1'b0;
assign param_write = state == ST_VER || state == ST_TLO || state == ST_THI;
assign cmd_done = state == ST_DONE;

always_comb begin
	case (state)
		ST_VER: param_data.as_value = `FW_VERSION;
		ST_TLO: param_data.as_value = time_latched[31:0];
		ST_THI: param_data.as_value = time_latched[63:32];
		default: begin
			param_data.as_raw.pad = '0;
			param_data.as_raw.data = rsp_id; // Response ID with done.
		end
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= ST_IDLE;
		shutdown <= 1'b0;
	end else begin
		case (state)
			ST_IDLE: if (cmd_ready) begin
				time_latched <= systime;
				case (cmd_id)
					`CMD_GET_VERSION: begin
						rsp_id <= 8'(`RSP_GET_VERSION);
						state <= ST_VER;
					end
					`CMD_GET_TIME: begin
						rsp_id <= 8'(`RSP_GET_TIME);
						state <= ST_TLO;
					end
					`CMD_SHUTDOWN: begin
						shutdown <= 1'b1; // Sticky until reset.
						state <= ST_DONE;
					end
					default: state <= ST_DONE;
				endcase
			end
			ST_VER: state <= ST_DONE;
			ST_TLO: state <= ST_THI;
			ST_THI: state <= ST_DONE;
			default: state <= ST_IDLE;
		endcase
	end
end

endmodule

`default_nettype wire

// ==== rtl/gpio_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module gpio_unit (
	input wire clk,
	input wire reset,
	input wire [`CMD_ID_BITS-1:0] cmd_id,
	input wire [`ARG_BITS-1:0] arg_data,
	input wire cmd_ready,
	output logic arg_advance,
	output logic cmd_done,
	input wire shutdown,
	output logic [`NGPIO-1:0] gpio
);

localparam PIN_BITS = $clog2(`NGPIO);
localparam [1:0] G_IDLE = 2'd0;
localparam [1:0] G_VALUE = 2'd1;
localparam [1:0] G_DONE = 2'd2;

logic [1:0] state;
logic [PIN_BITS-1:0] pin;
logic [`NGPIO-1:0] out_r;
logic set_cmd;

assign set_cmd = cmd_id == `CMD_SET_DIGITAL_OUT;
assign arg_advance = cmd_ready && set_cmd; // Value follows the pin.
assign cmd_done = state == G_VALUE || state == G_DONE;
assign gpio = shutdown ? '0 : out_r;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= G_IDLE;
		out_r <= '0;
	end else begin
		if (shutdown)
			out_r <= '0;
		case (state)
			G_IDLE: if (cmd_ready) begin
				pin <= arg_data[PIN_BITS-1:0];
				state <= set_cmd ? G_VALUE : G_DONE;
			end
			G_VALUE: begin
				if (!shutdown)
					out_r[pin] <= arg_data != '0;
				state <= G_IDLE;
			end
			default: state <= G_IDLE;
		endcase
	end
end

endmodule

`default_nettype wire

// ==== rtl/command_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module command_core (
	input wire clk,
	input wire reset,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output wire msg_rd_en,
	output wire [7:0] send_ring_data,
	output wire send_ring_wr_en,
	input wire send_ring_full,
	output wire [`LEN_BITS-1:0] send_fifo_data,
	output wire send_fifo_wr_en,
	input wire send_fifo_full,
	input wire [63:0] systime,
	output wire [`NGPIO-1:0] gpio,
	output wire shutdown
);

wire dispatch_idle;
wire arg_write;
wire [`ARG_IDX_BITS-1:0] arg_idx;
wire [`ARG_BITS-1:0] arg_data;
wire cmd_valid;
wire [`CMD_ID_BITS-1:0] cmd_id;
wire [`UNIT_BITS-1:0] cmd_unit;
wire cmd_has_response;

wire [`CMD_ID_BITS-1:0] unit_cmd_id;
wire [`ARG_BITS-1:0] unit_arg_data;
wire [`NUNITS-1:0] unit_cmd_ready;
wire [`NUNITS-1:0] unit_arg_advance;
wire [`NUNITS-1:0] unit_param_write;
wire cmd_pkg::param_word_u unit_param_data [`NUNITS];
wire [`NUNITS-1:0] unit_param_raw;
wire [`NUNITS-1:0] unit_cmd_done;

wire param_write;
wire cmd_pkg::param_word_u param_data;
wire param_raw;
wire rsp_start;
wire [7:0] rsp_id;
wire rsp_busy;

cmd_parser u_parser (
	.clk(clk),
	.reset(reset),
	.msg_data(msg_data),
	.msg_ready(msg_ready),
	.msg_rd_en(msg_rd_en),
	.dispatch_idle(dispatch_idle),
	.arg_write(arg_write),
	.arg_idx(arg_idx),
	.arg_data(arg_data),
	.cmd_valid(cmd_valid),
	.cmd_id(cmd_id),
	.cmd_unit(cmd_unit),
	.cmd_has_response(cmd_has_response)
);

cmd_dispatch u_dispatch (
	.clk(clk),
	.reset(reset),
	.arg_write(arg_write),
	.arg_idx(arg_idx),
	.arg_data(arg_data),
	.cmd_valid(cmd_valid),
	.cmd_id(cmd_id),
	.cmd_unit(cmd_unit),
	.cmd_has_response(cmd_has_response),
	.dispatch_idle(dispatch_idle),
	.unit_cmd_id(unit_cmd_id),
	.unit_arg_data(unit_arg_data),
	.unit_cmd_ready(unit_cmd_ready),
	.unit_arg_advance(unit_arg_advance),
	.unit_param_write(unit_param_write),
	.unit_param_data(unit_param_data),
	.unit_param_raw(unit_param_raw),
	.unit_cmd_done(unit_cmd_done),
	.param_write(param_write),
	.param_data(param_data),
	.param_raw(param_raw),
	.rsp_start(rsp_start),
	.rsp_id(rsp_id),
	.rsp_busy(rsp_busy)
);

rsp_encoder u_encoder (
	.clk(clk),
	.reset(reset),
	.param_write(param_write),
	.param_data(param_data),
	.param_raw(param_raw),
	.rsp_start(rsp_start),
	.rsp_id(rsp_id),
	.rsp_busy(rsp_busy),
	.send_ring_data(send_ring_data),
	.send_ring_wr_en(send_ring_wr_en),
	.send_ring_full(send_ring_full),
	.send_fifo_data(send_fifo_data),
	.send_fifo_wr_en(send_fifo_wr_en),
	.send_fifo_full(send_fifo_full)
);

system_unit u_system (
	.clk(clk),
	.reset(reset),
	.systime(systime),
	.cmd_id(unit_cmd_id),
	.arg_data(unit_arg_data),
	.cmd_ready(unit_cmd_ready[`UNIT_SYSTEM]),
	.arg_advance(unit_arg_advance[`UNIT_SYSTEM]),
	.param_write(unit_param_write[`UNIT_SYSTEM]),
	.param_data(unit_param_data[`UNIT_SYSTEM]),
	.param_raw(unit_param_raw[`UNIT_SYSTEM]),
	.cmd_done(unit_cmd_done[`UNIT_SYSTEM]),
	.shutdown(shutdown)
);

// GPIO commands never answer.
assign unit_param_write[`UNIT_GPIO] = 1'b0;
assign unit_param_data[`UNIT_GPIO] = '0;
assign unit_param_raw[`UNIT_GPIO] = 1'b0;

gpio_unit u_gpio (
	.clk(clk),
	.reset(reset),
	.cmd_id(unit_cmd_id),
	.arg_data(unit_arg_data),
	.cmd_ready(unit_cmd_ready[`UNIT_GPIO]),
	.arg_advance(unit_arg_advance[`UNIT_GPIO]),
	.cmd_done(unit_cmd_done[`UNIT_GPIO]),
	.shutdown(shutdown),
	.gpio(gpio)
);

endmodule

`default_nettype wire

// ==== sim/tb_command.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cmd_cfg.svh"

module tb_command;

localparam int WAIT_LIMIT = 4000;

logic clk;
logic reset;
logic [7:0] msg_data;
logic msg_ready;
logic msg_rd_en;
logic [7:0] send_ring_data;
logic send_ring_wr_en;
logic send_ring_full;
logic [`LEN_BITS-1:0] send_fifo_data;
logic send_fifo_wr_en;
logic send_fifo_full;
logic [63:0] systime;
logic [`NGPIO-1:0] gpio;
logic shutdown;

logic [7:0] rx_q[$]; // Host bytes waiting in the receive queue.
logic [7:0] got[$]; // Ring bytes of the response in progress.
logic exp_kind[$]; // 1 for get_time, 0 for get_version.
logic [`NGPIO-1:0] exp_gpio[$];
logic exp_shutdown[$];
logic [63:0] exp_tmin[$];
logic [63:0] first_time;
logic [`NGPIO-1:0] model_gpio;
logic model_shutdown;
int rd_pos;
int unsigned sel;
int k;

command_core u_dut (
	.clk(clk),
	.reset(reset),
	.msg_data(msg_data),
	.msg_ready(msg_ready),
	.msg_rd_en(msg_rd_en),
	.send_ring_data(send_ring_data),
	.send_ring_wr_en(send_ring_wr_en),
	.send_ring_full(send_ring_full),
	.send_fifo_data(send_fifo_data),
	.send_fifo_wr_en(send_fifo_wr_en),
	.send_fifo_full(send_fifo_full),
	.systime(systime),
	.gpio(gpio),
	.shutdown(shutdown)
);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

task automatic abort_run();
	$display("Regression failed");
	$fatal(1, "Stopped at the first error.");
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_len(input string name, input logic [`LEN_BITS-1:0] exp,
		input logic [`LEN_BITS-1:0] act);
	if (act !== exp) begin
		$display("** Error at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_gpio(input string name, input logic [`NGPIO-1:0] exp,
		input logic [`NGPIO-1:0] act);
	if (act !== exp) begin
		$display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_time(input string name, input logic [63:0] lo, input logic [63:0] hi,
		input logic [63:0] act);
	if (act < lo || act > hi) begin
		$display("** Error at %0t: %s expected %h..%h, actual %h", $time, name, lo, hi, act);
		abort_run();
	end
endtask

// Minimal signed VLQ length.
function automatic int vlq_len(input logic signed [31:0] v);
	if (v >= -32 && v <= 95)
		return 1;
	if (v >= -4096 && v <= 12287)
		return 2;
	if (v >= -(1 << 19) && v <= 3 * (1 << 19) - 1)
		return 3;
	if (v >= -(1 << 26) && v <= 3 * (1 << 26) - 1)
		return 4;
	return 5;
endfunction

// Byte carrying 7-bit group i, counted from the least significant end.
function automatic logic [7:0] vlq_byte(input logic signed [31:0] v, input int i);
	logic signed [31:0] grp;
	grp = v >>> (7 * i);
	return {i != 0, grp[6:0]};
endfunction

function automatic logic [31:0] random_arg();
	case ($urandom_range(4))
		0: return $urandom_range(127) - 32'd32;
		1: return $urandom_range(16383) - 32'd4096;
		2: return $urandom_range(2097151) - 32'd524288;
		3: return $urandom_range(268435455) - 32'd67108864;
		default: return $urandom;
	endcase
endfunction

task automatic push_arg(input logic [31:0] v);
	int i;
	for (i = vlq_len(v) - 1; i >= 0; i--)
		rx_q.push_back(vlq_byte(v, i));
endtask

task automatic wait_rx_empty();
	int cycles;
	cycles = 0;
	while (rx_q.size() != 0) begin
		@(negedge clk);
		cycles++;
		if (cycles > WAIT_LIMIT) begin
			$display("Timeout: the DUT stopped reading command bytes.");
			abort_run();
		end
	end
endtask

task automatic wait_responses_done();
	int cycles;
	cycles = 0;
	while (exp_kind.size() != 0 || rx_q.size() != 0) begin
		@(negedge clk);
		cycles++;
		if (cycles > WAIT_LIMIT) begin
			$display("Timeout: expected responses never arrived.");
			abort_run();
		end
	end
endtask

task automatic send_query(input logic is_time);
	wait_rx_empty();
	rx_q.push_back(is_time ? 8'(`CMD_GET_TIME) : 8'(`CMD_GET_VERSION));
	exp_kind.push_back(is_time);
	exp_gpio.push_back(model_gpio);
	exp_shutdown.push_back(model_shutdown);
	exp_tmin.push_back(systime); // Lower bound for the latched time.
endtask

task automatic send_set_out(input logic [31:0] pin, input logic [31:0] value);
	wait_rx_empty();
	rx_q.push_back(8'(`CMD_SET_DIGITAL_OUT));
	push_arg(pin);
	push_arg(value);
	if (!model_shutdown)
		model_gpio[pin[2:0]] = value != 0;
endtask

task automatic send_single(input logic [7:0] id);
	wait_rx_empty();
	rx_q.push_back(id);
	if (id == `CMD_SHUTDOWN) begin
		model_shutdown = 1'b1;
		model_gpio = '0;
	end
endtask

task automatic decode_vlq(output logic [31:0] v);
	logic [7:0] b;
	int n;
	n = 0;
	v = '0;
	do begin
		if (rd_pos >= got.size()) begin
			$display("Response ended in the middle of a get_time value.");
			abort_run();
		end
		b = got[rd_pos];
		rd_pos++;
		if (n == 0)
			v = {{25{b[6] & b[5]}}, b[6:0]};
		else
			v = {v[24:0], b[6:0]};
		n++;
	end while (b[7] && n < 5);
endtask

task automatic check_response();
	logic [7:0] want[$];
	logic [31:0] lo_word;
	logic [31:0] hi_word;
	logic [63:0] tmin;
	logic [`NGPIO-1:0] gpio_want;
	logic shutdown_want;
	logic is_time;
	int i;
	if (exp_kind.size() == 0) begin
		$display("Response length written with no command outstanding.");
		abort_run();
	end
	is_time = exp_kind.pop_front();
	tmin = exp_tmin.pop_front();
	gpio_want = exp_gpio.pop_front();
	shutdown_want = exp_shutdown.pop_front();
	if (is_time) begin
		want.push_back(8'(`RSP_GET_TIME));
		rd_pos = 1;
		decode_vlq(lo_word);
		decode_vlq(hi_word);
		check_time("get_time value", tmin, first_time, {hi_word, lo_word});
		for (i = vlq_len(lo_word) - 1; i >= 0; i--)
			want.push_back(vlq_byte(lo_word, i));
		for (i = vlq_len(hi_word) - 1; i >= 0; i--)
			want.push_back(vlq_byte(hi_word, i));
	end else begin
		want.push_back(8'(`RSP_GET_VERSION));
		for (i = vlq_len(`FW_VERSION) - 1; i >= 0; i--)
			want.push_back(vlq_byte(`FW_VERSION, i));
	end
	check_len("send_fifo_data", `LEN_BITS'(want.size()), send_fifo_data);
	check_len("ring byte count", `LEN_BITS'(want.size()), `LEN_BITS'(got.size()));
	for (i = 0; i < want.size(); i++)
		check_byte("send_ring_data", want[i], got[i]);
	check_gpio("gpio", gpio_want, gpio);
	check_flag("shutdown", shutdown_want, shutdown);
	got.delete();
endtask

// Inputs change on the falling edge.
always @(negedge clk) begin
	systime <= systime + 1'b1;
	send_ring_full <= $urandom_range(2) == 0;
	send_fifo_full <= $urandom_range(3) == 0;
	if (msg_rd_en) begin
		if (rx_q.size() == 0) begin
			$display("The DUT popped a byte from an empty receive queue.");
			abort_run();
		end else begin
			rx_q.delete(0);
		end
	end
	msg_ready <= rx_q.size() != 0;
	msg_data <= (rx_q.size() != 0) ? rx_q[0] : 8'h00;
end

always @(posedge clk) begin
	if (!reset) begin
		if (send_ring_wr_en && send_ring_full) begin
			$display("The DUT wrote the send ring while it was full.");
			abort_run();
		end
		if (send_fifo_wr_en && send_fifo_full) begin
			$display("The DUT wrote the send length FIFO while it was full.");
			abort_run();
		end
		if (send_ring_wr_en) begin
			if (got.size() == 0)
				first_time = systime;
			got.push_back(send_ring_data);
		end
		if (send_fifo_wr_en)
			check_response();
	end
end

initial begin
	void'($urandom(1966));
	reset = 1'b1;
	msg_data = 8'h00;
	msg_ready = 1'b0;
	send_ring_full = 1'b0;
	send_fifo_full = 1'b0;
	systime = {$urandom, $urandom}; // Large words give long responses.
	model_gpio = '0;
	model_shutdown = 1'b0;
	repeat (16) @(negedge clk);
	reset = 1'b0;
	check_gpio("gpio", '0, gpio);
	check_flag("shutdown", 1'b0, shutdown);
	send_query(1'b0);
	for (k = 0; k < 80; k++) begin
		sel = $urandom_range(9);
		if (sel < 2)
			send_query(1'b0);
		else if (sel < 5)
			send_query(1'b1);
		else if (sel < 9)
			send_set_out($urandom_range(7), $urandom_range(1) ? random_arg() : 32'd0);
		else
			send_single(8'd7); // Undefined ID.
	end
	send_query(1'b0);
	wait_responses_done();
	check_gpio("gpio", model_gpio, gpio);
	check_flag("shutdown", model_shutdown, shutdown);
	send_single(8'(`CMD_SHUTDOWN));
	send_query(1'b0);
	for (k = 0; k < 20; k++) begin
		send_set_out($urandom_range(7), random_arg() | 32'd1);
		if ($urandom_range(1))
			send_query(1'b0);
	end
	send_query(1'b1);
	send_query(1'b0);
	wait_responses_done();
	check_gpio("gpio", '0, gpio);
	check_flag("shutdown", 1'b1, shutdown);
	$display("Regression passed");
	$finish;
end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/cmd_pkg.sv
command/cmd_parser.sv
command/cmd_dispatch.sv
command/rsp_encoder.sv
rtl/system_unit.sv
rtl/gpio_unit.sv
rtl/command_core.sv
sim/tb_command.sv

// ==== Bender.yml ====
package:
  name: command_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cmd_pkg.sv
      - command/cmd_parser.sv
      - command/cmd_dispatch.sv
      - command/rsp_encoder.sv
      - rtl/system_unit.sv
      - rtl/gpio_unit.sv
      - rtl/command_core.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_command.sv
